// ==== tb/mmu_vectors.txt ====
# M byte_addr word | S satp_mode root_ppn sum | R priv kind vaddr walks fault paddr
# P priv data_vaddr data_paddr insn_vaddr insn_paddr; priv 0=U 1=S 3=M, kind 1=load 2=store 3=fetch
M 00001004 00000801
M 00001008 001000CF
M 0000100C 001004CB
M 00001010 00000805
M 00001014 00000C00
M 00002040 048D14C7
M 00002044 002AF04B
M 00002048 000C8443
M 0000204C 001DDCD7
S 0 001 0
R 1 1 00410234 0 0 000410234
S 1 001 0
R 3 3 80001000 0 0 080001000
R 0 1 00412008 1 1 000000000
R 1 1 00410234 1 0 012345234
R 1 1 00410234 0 0 012345234
R 1 3 00411100 1 0 000ABC100
R 1 3 00411100 0 0 000ABC100
R 1 1 009550AB 1 0 0005550AB
R 1 1 00C01000 1 1 000000000
R 1 2 00412008 1 1 000000000
R 1 3 00410234 1 1 000000000
R 1 3 01400000 1 1 000000000
R 1 1 01000000 1 1 000000000
R 1 1 00413010 1 1 000000000
S 1 001 1
R 1 1 00413010 1 0 000777010
R 0 1 00413010 0 0 000777010
P 1 00956040 000556040 00957010 000557010

// ==== verilog.f ====
common/sv32_types_pkg.sv
common/priv_types_pkg.sv
hw/tlb/tlb.sv
hw/walk_arbiter.sv
hw/page_walker/page_walker.sv
hw/mmu_top.sv
tb/clock_gen.sv
tb/tb_mmu.sv

// ==== Makefile ====
# Verilator build and run for the Sv32 MMU testbench

VERILATOR ?= verilator
TOP       ?= tb_mmu
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_mmu.sv ====
/*
 * MMU testbench
 * Page table memory model behind the walker, translation requests
 * from the vector file, checks of paddr, fault strobes and walk counts.
 */
module tb_mmu
    import sv32_types_pkg::*, priv_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT   = 200; // cycles per wait
    localparam int MEM_WORDS = 4096;

    logic        CLK, nRST;
    xlate_req_t  ireq, dreq;
    xlate_rsp_t  iresp, dresp;
    satp_t       satp;
    priv_level_t priv;
    logic        sum;
    fault_t      fault;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    logic [31:0] pt_mem [MEM_WORDS];
    logic [31:0] seed = 32'h80e5;
    int          walk_count;
    int          checks, paddr_errors, fault_errors, count_errors, other_errors;
    logic        abort;

    clock_gen u_clk (
        .CLK  (CLK),
        .nRST (nRST)
    );

    mmu_top dut (
        .CLK     (CLK),
        .nRST    (nRST),
        .ireq    (ireq),
        .dreq    (dreq),
        .iresp   (iresp),
        .dresp   (dresp),
        .satp    (satp),
        .priv    (priv),
        .sum     (sum),
        .fault   (fault),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] read_word(input logic [PADDR_W-1:0] addr);
        if (addr >= PADDR_W'(MEM_WORDS * 4)) begin
            $display("page table read at %h is outside the memory model", addr);
            other_errors++;
            return 32'h0;
        end
        return pt_mem[addr[13:2]];
    endfunction

    task automatic check_paddr(input string name, input logic [PADDR_W-1:0] expected,
                               input logic [PADDR_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            paddr_errors++;
        end
    endtask

    task automatic check_fault(input string name, input fault_t expected, input fault_t actual);
        checks++;
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            fault_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            count_errors++;
        end
    endtask

    // one request on one side, held until busy drops or a fault strobe
    task automatic run_request(input int p, input int k, input logic [31:0] va, input int walks,
                               input int flt, input logic [PADDR_W-1:0] exp_pa);
        int                 walks_before;
        int                 cycles;
        logic               done;
        logic [PADDR_W-1:0] got_pa;
        fault_t             got_f;
        fault_t             exp_f;
        xlate_rsp_t         rsp;
        priv = priv_level_t'(p[1:0]);
        walks_before = walk_count;
        if (k == 3) begin
            ireq = '{ren: 1'b1, wen: 1'b0, vaddr: va};
        end else begin
            dreq = '{ren: (k == 1), wen: (k == 2), vaddr: va};
        end
        done = 1'b0;
        cycles = 0;
        got_f = '0;
        got_pa = '0;
        while (!done && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            rsp = (k == 3) ? iresp : dresp;
            if (|fault) begin
                got_f = fault;
                done = 1'b1;
            end else if (!rsp.busy) begin
                got_pa = rsp.paddr;
                done = 1'b1;
            end
        end
        ireq = '0; // core drops the request
        dreq = '0;
        if (!done) begin
            $display("no response to translation request at %0t ns", $time);
            other_errors++;
            abort = 1'b1;
        end else begin
            exp_f.load  = (flt != 0) && (k == 1);
            exp_f.store = (flt != 0) && (k == 2);
            exp_f.insn  = (flt != 0) && (k == 3);
            check_fault("fault", exp_f, got_f);
            if (flt == 0 && got_f == '0) begin
                check_paddr((k == 3) ? "iresp.paddr" : "dresp.paddr", exp_pa, got_pa);
            end
            check_count("walks", walks, walk_count - walks_before);
        end
    endtask

    // data load and instruction fetch presented in the same cycle
    task automatic run_pair(input int p, input logic [31:0] dva, input logic [PADDR_W-1:0] dpa,
                            input logic [31:0] iva, input logic [PADDR_W-1:0] ipa);
        int                 cycles;
        int                 d_cycle;
        int                 i_cycle;
        logic [PADDR_W-1:0] d_got;
        logic [PADDR_W-1:0] i_got;
        priv = priv_level_t'(p[1:0]);
        dreq = '{ren: 1'b1, wen: 1'b0, vaddr: dva};
        ireq = '{ren: 1'b1, wen: 1'b0, vaddr: iva};
        cycles = 0;
        d_cycle = 0;
        i_cycle = 0;
        d_got = '0;
        i_got = '0;
        while ((d_cycle == 0 || i_cycle == 0) && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            if (|fault) begin
                $display("page fault during the simultaneous misses at %0t ns", $time);
                other_errors++;
            end
            if (d_cycle == 0 && !dresp.busy) begin
                d_got = dresp.paddr;
                d_cycle = cycles;
                dreq = '0;
            end
            if (i_cycle == 0 && !iresp.busy) begin
                i_got = iresp.paddr;
                i_cycle = cycles;
                ireq = '0;
            end
        end
        ireq = '0;
        dreq = '0;
        if (d_cycle == 0 || i_cycle == 0) begin
            $display("no response to translation request at %0t ns", $time);
            other_errors++;
            abort = 1'b1;
        end else begin
            check_paddr("dresp.paddr", dpa, d_got);
            check_paddr("iresp.paddr", ipa, i_got);
            if (d_cycle >= i_cycle) begin
                $display("instruction miss finished before the data miss at %0t ns", $time);
                other_errors++;
            end
        end
    endtask

    // answers each read after 0 to 3 busy cycles
    initial begin : mem_model
        logic        ren_prev;
        logic        active;
        int          wait_left;
        logic [31:0] r;
        mem_rsp = '{busy: 1'b1, rdata: '0};
        ren_prev = 1'b0;
        active = 1'b0;
        wait_left = 0;
        forever begin
            @(negedge CLK);
            mem_rsp.busy = 1'b1;
            if (mem_req.ren) begin
                if (!ren_prev) begin
                    walk_count++; // ren stays high over both levels
                end
                if (!active) begin
                    r = lcg_next();
                    wait_left = int'(r[17:16]);
                    active = 1'b1;
                end
                if (wait_left == 0) begin
                    mem_rsp = '{busy: 1'b0, rdata: read_word(mem_req.addr)};
                    active = 1'b0;
                end else begin
                    wait_left--;
                end
            end else begin
                active = 1'b0;
            end
            ren_prev = mem_req.ren;
        end
    end

    initial begin : main
        int                 fd;
        int                 c;
        int                 n;
        int                 cycles;
        logic               at_end;
        logic [7:0]         ch;
        logic [31:0]        m_addr, m_word;
        int                 s_mode, s_sum;
        logic [PPN_W-1:0]   s_root;
        int                 r_priv, r_kind, r_walks, r_fault;
        logic [31:0]        r_vaddr, p_vaddr;
        logic [PADDR_W-1:0] r_paddr, p_paddr;
        ireq = '0;
        dreq = '0;
        satp = '0;
        priv = PRIV_M;
        sum = 1'b0;
        abort = 1'b0;
        at_end = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            pt_mem[i] = (32'(i) * 32'h9e37_79b1) & 32'hffff_fffe; // V clear
        end
        cycles = 0;
        while (nRST !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (nRST !== 1'b1) begin
            $display("reset was never released");
            other_errors++;
            abort = 1'b1;
        end
        @(negedge CLK);
        fd = $fopen("tb/mmu_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/mmu_vectors.txt");
            other_errors++;
            abort = 1'b1;
        end
        while (!abort && !at_end) begin
            c = $fgetc(fd);
            if (c < 0) begin
                at_end = 1'b1;
            end else begin
                ch = c[7:0];
                n = 0;
                case (ch)
                    "#": begin
                        while (c >= 0 && c != 10) begin
                            c = $fgetc(fd);
                        end
                        n = -1;
                    end
                    "M": begin
                        n = $fscanf(fd, " %h %h", m_addr, m_word);
                        if (n == 2 && m_addr < 32'(MEM_WORDS * 4)) begin
                            pt_mem[m_addr[13:2]] = m_word;
                            n = -1;
                        end
                    end
                    "S": begin
                        n = $fscanf(fd, " %d %h %d", s_mode, s_root, s_sum);
                        if (n == 3) begin
                            satp = '{mode: s_mode[0], asid: '0, ppn: s_root};
                            sum = s_sum[0];
                            n = -1;
                        end
                    end
                    "R": begin
                        n = $fscanf(fd, " %d %d %h %d %d %h", r_priv, r_kind, r_vaddr,
                                    r_walks, r_fault, r_paddr);
                        if (n == 6 && r_kind >= 1 && r_kind <= 3) begin
                            run_request(r_priv, r_kind, r_vaddr, r_walks, r_fault, r_paddr);
                            n = -1;
                        end
                    end
                    "P": begin
                        n = $fscanf(fd, " %d %h %h %h %h", r_priv, r_vaddr, r_paddr,
                                    p_vaddr, p_paddr);
                        if (n == 5) begin
                            run_pair(r_priv, r_vaddr, r_paddr, p_vaddr, p_paddr);
                            n = -1;
                        end
                    end
                    " ", "\n", "\r", "\t": n = -1;
                    default: n = 0;
                endcase
                if (n != -1) begin
                    $display("malformed %c line in the vector file", ch);
                    other_errors++;
                    abort = 1'b1;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("checks %0d, errors: paddr %0d, fault %0d, walks %0d, other %0d",
                 checks, paddr_errors, fault_errors, count_errors, other_errors);
        if (!abort && checks > 0 &&
            paddr_errors + fault_errors + count_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/clock_gen.sv ====
/*
 * Clock and reset for the MMU testbench
 * 10 ns clock, nRST low over the first three rising edges
 */
module clock_gen (
    output logic CLK,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1; // released away from the rising edge
    end

endmodule

// ==== hw/mmu_top.sv ====
/*
 * Sv32 MMU top
 * Instruction and data TLBs with a shared page walker behind
 * a miss arbiter.
 */
module mmu_top
    import sv32_types_pkg::*, priv_types_pkg::*;
(
    input  logic        CLK, nRST,
    input  xlate_req_t  ireq, dreq,
    output xlate_rsp_t  iresp, dresp,
    input  satp_t       satp,
    input  priv_level_t priv,
    input  logic        sum,
    output fault_t      fault,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp
);

    logic      imiss, dmiss;
    logic      walk_done;
    walk_req_t walk_req;
    tlb_fill_t ifill, dfill;

    tlb itlb (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (ireq),
        .satp (satp),
        .priv (priv),
        .fill (ifill),
        .rsp  (iresp),
        .miss (imiss)
    );

    tlb dtlb (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (dreq),
        .satp (satp),
        .priv (priv),
        .fill (dfill),
        .rsp  (dresp),
        .miss (dmiss)
    );

    walk_arbiter u_arbiter (
        .CLK       (CLK),
        .nRST      (nRST),
        .imiss     (imiss),
        .dmiss     (dmiss),
        .ireq      (ireq),
        .dreq      (dreq),
        .walk_done (walk_done),
        .walk_req  (walk_req)
    );

    page_walker u_walker (
        .CLK       (CLK),
        .nRST      (nRST),
        .walk_req  (walk_req),
        .satp      (satp),
        .priv      (priv),
        .sum       (sum),
        .mem_rsp   (mem_rsp),
        .mem_req   (mem_req),
        .ifill     (ifill),
        .dfill     (dfill),
        .fault     (fault),
        .walk_done (walk_done)
    );

endmodule

// ==== hw/page_walker/page_walker.sv ====
/*
 * Sv32 page walker
 * Two-level table walk over the memory read bus, with leaf
 * permission, privilege and megapage checks. A good leaf refills
 * the TLB that missed, a bad one raises a page fault strobe.
 */
module page_walker
    import sv32_types_pkg::*, priv_types_pkg::*;
(
    input  logic        CLK, nRST,
    input  walk_req_t   walk_req,
    input  satp_t       satp,
    input  priv_level_t priv,
    input  logic        sum,
    input  mem_rsp_t    mem_rsp,
    output mem_req_t    mem_req,
    output tlb_fill_t   ifill, dfill,
    output fault_t      fault,
    output logic        walk_done
);

    typedef enum logic [1:0] {
        IDLE,
        WALK,
        FINISH
    } pw_state_t;

    pw_state_t             state;
    access_t               access;
    logic                  level; // 1 = root table
    va_t                   va;
    logic [PADDR_W-1:0]    page_address;
    pte_t                  pte;
    logic                  leaf, perm_bad, user_bad, misaligned, bad_pte;
    logic                  ifill_stb, dfill_stb;
    logic [1:0][VPN_W-1:0] fill_vpn;
    logic [PPN_W-1:0]      fill_ppn;
    pte_perms_t            fill_perms;

    assign pte  = pte_t'(mem_rsp.rdata);
    assign leaf = pte.perms.r | pte.perms.x;

    always_comb begin
        case (access)
            INSTRUCTION: perm_bad = !pte.perms.x;
            STORE:       perm_bad = !pte.perms.w;
            LOAD:        perm_bad = !pte.perms.r;
            default:     perm_bad = 1'b0;
        endcase
    end

    assign user_bad   = (pte.perms.u && priv == PRIV_S && !sum) ||
                        (!pte.perms.u && priv == PRIV_U);
    assign misaligned = level && (pte.ppn[VPN_W-1:0] != '0); // megapage must be aligned

    // fault checks in priority order, leaf checks only apply to a leaf
    assign bad_pte = !pte.perms.v || (pte.perms.w && !pte.perms.r) ||
                     (!level && !(pte.perms.r || pte.perms.w || pte.perms.x)) ||
                     (leaf && (perm_bad || user_bad || misaligned));

    assign mem_req.ren  = (state == WALK);
    assign mem_req.addr = page_address;

    assign ifill = '{vpn: fill_vpn, ppn: fill_ppn, perms: fill_perms, fill: ifill_stb};
    assign dfill = '{vpn: fill_vpn, ppn: fill_ppn, perms: fill_perms, fill: dfill_stb};

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            state     <= IDLE;
            access    <= NONE;
            level     <= 1'b1;
            fault     <= '0;
            walk_done <= 1'b0;
            ifill_stb <= 1'b0;
            dfill_stb <= 1'b0;
        end else begin
            fault     <= '0;
            walk_done <= 1'b0;
            ifill_stb <= 1'b0;
            dfill_stb <= 1'b0;
            case (state)
                IDLE: begin
                    if (walk_req.start) begin
                        state  <= WALK;
                        access <= walk_req.kind;
                        level  <= 1'b1;
                    end
                end
                WALK: begin
                    if (!mem_rsp.busy) begin // pte valid this cycle
                        if (bad_pte) begin
                            fault.load  <= (access == LOAD);
                            fault.store <= (access == STORE);
                            fault.insn  <= (access == INSTRUCTION);
                            walk_done   <= 1'b1;
                            state       <= FINISH;
                        end else if (leaf) begin
                            ifill_stb <= (access == INSTRUCTION);
                            dfill_stb <= (access != INSTRUCTION);
                            walk_done <= 1'b1;
                            state     <= FINISH;
                        end else begin
                            level <= 1'b0; // pointer to next table
                        end
                    end
                end
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && walk_req.start) begin
            va           <= walk_req.vaddr;
            page_address <= {satp.ppn, walk_req.vaddr.vpn[1], 2'b00};
        end else if (state == WALK && !mem_rsp.busy) begin
            if (!leaf) begin
                page_address <= {pte.ppn, va.vpn[0], 2'b00};
            end
            fill_vpn   <= va.vpn;
            fill_ppn   <= level ? {pte.ppn[PPN_W-1:VPN_W], va.vpn[0]} : pte.ppn;
            fill_perms <= pte.perms;
        end
    end

    // a new walk arrives only once the previous one has finished
    a_start_when_idle: assert property (@(posedge CLK) disable iff (!nRST)
        walk_req.start |-> state == IDLE);

    // every walk carries a real access kind, so a fault names exactly one
    a_start_kind: assert property (@(posedge CLK) disable iff (!nRST)
        walk_req.start |-> walk_req.kind != NONE);

endmodule

// ==== hw/walk_arbiter.sv ====
/*
 * Walk arbiter
 * Picks a data TLB miss over an instruction TLB miss and hands
 * one walk at a time to the page walker.
 */
module walk_arbiter
    import sv32_types_pkg::*, priv_types_pkg::*;
(
    input  logic       CLK, nRST,
    input  logic       imiss, dmiss,
    input  xlate_req_t ireq, dreq,
    input  logic       walk_done,
    output walk_req_t  walk_req
);

    logic    busy;
    logic    start_q;
    access_t kind_q;
    va_t     vaddr_q;
    logic    grant;

    assign grant    = !busy && (dmiss || imiss);
    assign walk_req = '{start: start_q, kind: kind_q, vaddr: vaddr_q};

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            busy    <= 1'b0;
            start_q <= 1'b0;
            kind_q  <= NONE;
        end else begin
            start_q <= grant; // single pulse, busy blocks the next
            if (grant) begin
                busy <= 1'b1;
                if (dmiss) begin
                    kind_q <= dreq.ren ? LOAD : STORE;
                end else begin
                    kind_q <= INSTRUCTION;
                end
            end else if (walk_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (grant) begin
            vaddr_q <= dmiss ? va_t'(dreq.vaddr) : va_t'(ireq.vaddr);
        end
    end

    // the walker only finishes a walk that was handed to it
    a_done_while_busy: assert property (@(posedge CLK) disable iff (!nRST)
        walk_done |-> busy);

endmodule

// ==== hw/tlb/tlb.sv ====
/*
 * Direct-mapped TLB
 * Translates a held core request in the same cycle, passes the
 * address through when paging is off, and raises miss until the
 * page walker refills the entry.
 */
module tlb
    import sv32_types_pkg::*, priv_types_pkg::*;
(
    input  logic        CLK, nRST,
    input  xlate_req_t  req,
    input  satp_t       satp,
    input  priv_level_t priv,
    input  tlb_fill_t   fill,
    output xlate_rsp_t  rsp,
    output logic        miss
);

    logic [TLB_SETS-1:0]  valid;
    logic [TLB_SETS-1:0]  writable;
    logic [TLB_TAG_W-1:0] tags [TLB_SETS];
    logic [PPN_W-1:0]     ppns [TLB_SETS];

    va_t                  va;
    logic [TLB_IDX_W-1:0] idx, fill_idx;
    logic [TLB_TAG_W-1:0] tag, fill_tag;
    logic                 xlate_on, req_on, hit;

    assign va       = va_t'(req.vaddr);
    assign idx      = va.vpn[0][TLB_IDX_W-1:0];
    assign tag      = {va.vpn[1], va.vpn[0][VPN_W-1:TLB_IDX_W]};
    assign fill_idx = fill.vpn[0][TLB_IDX_W-1:0];
    assign fill_tag = {fill.vpn[1], fill.vpn[0][VPN_W-1:TLB_IDX_W]};

    assign xlate_on = satp.mode && (priv == PRIV_S || priv == PRIV_U);
    assign req_on   = req.ren | req.wen;

    // a store to an entry without W misses, so the walker raises the fault
    assign hit = valid[idx] && (tags[idx] == tag) && (!req.wen || writable[idx]);

    always_comb begin
        if (xlate_on) begin
            rsp.paddr = {ppns[idx], va.offset};
        end else begin
            rsp.paddr = {{(PADDR_W - VADDR_W){1'b0}}, req.vaddr}; // bare mode
        end
    end

    assign miss     = xlate_on && req_on && !hit;
    assign rsp.busy = miss;

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            valid <= '0;
        end else if (fill.fill) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill.fill) begin
            tags[fill_idx]     <= fill_tag;
            ppns[fill_idx]     <= fill.ppn;
            writable[fill_idx] <= fill.perms.w;
        end
    end

    // refill only ever targets a set that is currently missing
    a_fill_no_hit: assert property (@(posedge CLK) disable iff (!nRST)
        fill.fill |-> !(xlate_on && req_on && hit && idx == fill_idx));

endmodule

// ==== common/priv_types_pkg.sv ====
/*
 * Privilege and access types
 * Privilege levels, access kinds, page fault strobes and the
 * core-side and walker request records.
 */
package priv_types_pkg;
    import sv32_types_pkg::*;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_level_t;

    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE,
        INSTRUCTION
    } access_t;

    typedef struct packed {
        logic load;
        logic store;
        logic insn;
    } fault_t;

    typedef struct packed {
        logic               ren;
        logic               wen;
        logic [VADDR_W-1:0] vaddr;
    } xlate_req_t;

    typedef struct packed {
        logic               busy;
        logic [PADDR_W-1:0] paddr;
    } xlate_rsp_t;

    typedef struct packed {
        logic    start; // one cycle
        access_t kind;
        va_t     vaddr;
    } walk_req_t;

endpackage

// ==== common/sv32_types_pkg.sv ====
/*
 * Sv32 paging types
 * Address widths, page table entry layout, satp, TLB refill record
 * and the page table memory bus.
 */
package sv32_types_pkg;

    localparam int VADDR_W     = 32;
    localparam int PADDR_W     = 34;
    localparam int PGSIZE_BITS = 12; // 4 KiB pages
    localparam int PPN_W       = 22;
    localparam int VPN_W       = 10;
    localparam int TLB_SETS    = 16;
    localparam int TLB_IDX_W   = $clog2(TLB_SETS);
    localparam int TLB_TAG_W   = 2 * VPN_W - TLB_IDX_W; // vpn bits above the index

    typedef struct packed {
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_perms_t;

    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        pte_perms_t       perms;
    } pte_t;

    typedef struct packed {
        logic [1:0][VPN_W-1:0]  vpn; // vpn[1] selects the root entry
        logic [PGSIZE_BITS-1:0] offset;
    } va_t;

    typedef struct packed {
        logic             mode; // 1 = Sv32
        logic [8:0]       asid;
        logic [PPN_W-1:0] ppn;
    } satp_t;

    // megapage low ppn bits are already merged by the walker
    typedef struct packed {
        logic [1:0][VPN_W-1:0] vpn;
        logic [PPN_W-1:0]      ppn;
        pte_perms_t            perms;
        logic                  fill;
    } tlb_fill_t;

    typedef struct packed {
        logic               ren;
        logic [PADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic        busy;
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage
